// File: design/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// SRAM size in 32-bit words
// Byte addresses at or above 4x this value take an error response
`define BUS_SRAM_DEPTH_WORDS 1024

// Wait states inserted into every data phase
`define BUS_SRAM_WAIT 1

// HMASTER values
`define BUS_MASTER_ID_CORE 8'h00
`define BUS_MASTER_ID_DBG  8'h01

`endif

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// ------------------------------------------------------------------
	// Bus vector types

	// Byte address and data word
	typedef logic [31:0] haddr_t;
	typedef logic [31:0] hdata_t;

	// Transfer size code, byte/halfword/word only
	typedef logic [2:0]  hsize_t;
	typedef logic [1:0]  htrans_t;
	typedef logic [3:0]  hprot_t;
	typedef logic [7:0]  hmaster_t;

	// One-hot grant, {fetch, data, debug}
	typedef logic [2:0]  grant_t;

	// ------------------------------------------------------------------
	// Encodings

	localparam htrans_t HTRANS_IDLE   = 2'b00;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;

	localparam hsize_t HSIZE_BYTE = 3'd0;
	localparam hsize_t HSIZE_HALF = 3'd1;
	localparam hsize_t HSIZE_WORD = 3'd2;

	localparam grant_t GNT_NONE  = 3'b000;
	localparam grant_t GNT_FETCH = 3'b100;
	localparam grant_t GNT_DATA  = 3'b010;
	localparam grant_t GNT_DEBUG = 3'b001;

	// SRAM slave FSM
	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR_FIRST, ST_ERR_SECOND} sram_state_e;

endpackage

`default_nettype wire

// File: design/ahb_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ahb_if;
	import bus_pkg::*;

	// Address phase, from the manager
	haddr_t   haddr;
	logic     hwrite;
	htrans_t  htrans;
	hsize_t   hsize;
	hprot_t   hprot;
	hmaster_t hmaster;
	logic     hexcl;

	// Data phase write data, from the manager
	hdata_t   hwdata;

	// Response, from the subordinate
	logic     hready;
	logic     hresp;
	logic     hexokay;
	hdata_t   hrdata;

	modport manager (
		output haddr, hwrite, htrans, hsize, hprot, hmaster, hexcl, hwdata,
		input  hready, hresp, hexokay, hrdata
	);

	modport subordinate (
		input  haddr, hwrite, htrans, hsize, hprot, hmaster, hexcl, hwdata,
		output hready, hresp, hexokay, hrdata
	);

endinterface

`default_nettype wire

// File: design/ahb_port_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module ahb_port_arbiter (
	input  wire                    clk,
	input  wire                    rst_n,

	// Instruction fetch requester
	input  wire                    i_aph_req_i,
	input  wire                    i_aph_panic_i,
	input  wire bus_pkg::haddr_t   i_haddr_i,
	input  wire bus_pkg::hsize_t   i_hsize_i,
	input  wire                    i_priv_i,
	output logic                   i_aph_ready_o,
	output logic                   i_dph_ready_o,
	output logic                   i_dph_err_o,
	output bus_pkg::hdata_t        i_rdata_o,

	// Load/store requester
	input  wire                    d_aph_req_i,
	input  wire                    d_aph_excl_i,
	input  wire bus_pkg::haddr_t   d_haddr_i,
	input  wire bus_pkg::hsize_t   d_hsize_i,
	input  wire                    d_priv_i,
	input  wire                    d_hwrite_i,
	input  wire bus_pkg::hdata_t   d_wdata_i,
	output logic                   d_aph_ready_o,
	output logic                   d_dph_ready_o,
	output logic                   d_dph_err_o,
	output logic                   d_dph_exokay_o,
	output bus_pkg::hdata_t        d_rdata_o,

	// Debugger system bus
	input  wire bus_pkg::haddr_t   s_addr_i,
	input  wire                    s_write_i,
	input  wire [1:0]              s_size_i,
	input  wire                    s_vld_i,
	input  wire bus_pkg::hdata_t   s_wdata_i,
	output logic                   s_rdy_o,
	output logic                   s_err_o,
	output bus_pkg::hdata_t        s_rdata_o,

	// Shared master port
	ahb_if.manager                 bus_o
);
	import bus_pkg::*;

	// ------------------------------------------------------------------
	// Grant

	grant_t gnt;
	grant_t gnt_prev;

	// Previous cycle had a NONSEQ stalled by hready low
	logic   hold_aph;

	// Data phase owners
	logic   dph_i;
	logic   dph_d;
	logic   dph_s;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_aph <= 1'b0;
			gnt_prev <= GNT_NONE;
		end else begin
			// Error first cycle also has hready low and is no stall
			hold_aph <= (bus_o.htrans == HTRANS_NONSEQ) && !bus_o.hready && !bus_o.hresp;
			gnt_prev <= gnt;
		end
	end

	// Panic fetch, then load/store, then debug, then normal fetch
	always_comb begin
		if (hold_aph)
			gnt = gnt_prev;
		else if (i_aph_req_i && i_aph_panic_i)
			gnt = GNT_FETCH;
		else if (d_aph_req_i)
			gnt = GNT_DATA;
		// Debug vld may be stale while debug still owns a data phase
		else if (s_vld_i && !dph_s)
			gnt = GNT_DEBUG;
		else if (i_aph_req_i)
			gnt = GNT_FETCH;
		else
			gnt = GNT_NONE;
	end

	// Owner advances whenever the bus moves
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_i <= 1'b0;
			dph_d <= 1'b0;
			dph_s <= 1'b0;
		end else if (bus_o.hready) begin
			dph_i <= (gnt == GNT_FETCH);
			dph_d <= (gnt == GNT_DATA);
			dph_s <= (gnt == GNT_DEBUG);
		end
	end

	// ------------------------------------------------------------------
	// Address phase mux

	hprot_t hprot_fetch;
	hprot_t hprot_data;
	hprot_t hprot_dbg;

	// Noncacheable and nonbufferable with bit 1 privileged and bit 0 data access
	assign hprot_fetch = {2'b00, i_priv_i, 1'b0};
	assign hprot_data  = {2'b00, d_priv_i, 1'b1};
	assign hprot_dbg   = 4'b0011;

	always_comb begin
		// Idle defaults
		bus_o.htrans  = HTRANS_IDLE;
		bus_o.haddr   = '0;
		bus_o.hwrite  = 1'b0;
		bus_o.hsize   = HSIZE_BYTE;
		bus_o.hprot   = '0;
		bus_o.hmaster = `BUS_MASTER_ID_CORE;
		bus_o.hexcl   = 1'b0;
		case (gnt)
			GNT_FETCH: begin
				bus_o.htrans = HTRANS_NONSEQ;
				bus_o.haddr  = i_haddr_i;
				bus_o.hsize  = i_hsize_i;
				bus_o.hprot  = hprot_fetch;
			end
			GNT_DATA: begin
				bus_o.htrans = HTRANS_NONSEQ;
				bus_o.haddr  = d_haddr_i;
				bus_o.hwrite = d_hwrite_i;
				bus_o.hsize  = d_hsize_i;
				bus_o.hprot  = hprot_data;
				bus_o.hexcl  = d_aph_excl_i;
			end
			GNT_DEBUG: begin
				bus_o.htrans  = HTRANS_NONSEQ;
				bus_o.haddr   = s_addr_i;
				bus_o.hwrite  = s_write_i;
				bus_o.hsize   = {1'b0, s_size_i};
				bus_o.hprot   = hprot_dbg;
				bus_o.hmaster = `BUS_MASTER_ID_DBG;
			end
			default: begin
				bus_o.htrans = HTRANS_IDLE;
			end
		endcase
	end

	// Write data follows the data phase, not the grant
	assign bus_o.hwdata = dph_s ? s_wdata_i : d_wdata_i;

	// ------------------------------------------------------------------
	// Response routing

	// Read data fans out; only the owner sees ready
	assign i_rdata_o = bus_o.hrdata;
	assign d_rdata_o = bus_o.hrdata;
	assign s_rdata_o = bus_o.hrdata;

	assign i_aph_ready_o = bus_o.hready && (gnt == GNT_FETCH);
	assign i_dph_ready_o = dph_i && bus_o.hready;
	assign i_dph_err_o   = dph_i && bus_o.hresp;

	// Err shows on both error cycles and ready only on the second
	assign d_aph_ready_o  = bus_o.hready && (gnt == GNT_DATA);
	assign d_dph_ready_o  = dph_d && bus_o.hready;
	assign d_dph_err_o    = dph_d && bus_o.hresp;
	assign d_dph_exokay_o = dph_d && bus_o.hexokay;

	assign s_rdy_o = dph_s && bus_o.hready;
	assign s_err_o = dph_s && bus_o.hresp;

	// ------------------------------------------------------------------
	// Checks

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt))
		else $error("arbiter grant not one-hot");

	a_htrans_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_o.htrans == HTRANS_NONSEQ) == (gnt != GNT_NONE))
		else $error("htrans does not match grant");

endmodule

`default_nettype wire

// File: design/ahb_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module ahb_sram #(
	parameter int DEPTH = `BUS_SRAM_DEPTH_WORDS,
	parameter int WAIT  = `BUS_SRAM_WAIT
) (
	input  wire        clk,
	input  wire        rst_n,
	ahb_if.subordinate bus_i
);
	import bus_pkg::*;

	localparam int     AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int     CW    = (WAIT > 1) ? $clog2(WAIT) : 1;
	// First byte address past the array
	localparam haddr_t LIMIT = haddr_t'(4 * DEPTH);

	sram_state_e   state;
	logic [CW-1:0] wait_cnt;

	// Address phase decode
	logic          aph_accept;
	logic          aph_in_range;
	logic [3:0]    aph_lanes;

	// Captured data phase
	logic          dph_vld;
	logic [AW-1:0] dph_word;
	logic          dph_write;
	logic          dph_excl;
	logic [3:0]    dph_lanes;
	hmaster_t      dph_master;
	logic          dph_done;

	// Exclusive reservation
	logic          resv_vld;
	logic [AW-1:0] resv_word;
	hmaster_t      resv_master;
	logic          excl_ok;

	hdata_t        mem [DEPTH];

	// ------------------------------------------------------------------
	// Address phase

	assign aph_accept   = (bus_i.htrans == HTRANS_NONSEQ) && bus_i.hready;
	assign aph_in_range = bus_i.haddr < LIMIT;

	// Byte lanes from size and low address bits
	always_comb begin
		case (bus_i.hsize)
			HSIZE_BYTE: aph_lanes = 4'b0001 << bus_i.haddr[1:0];
			HSIZE_HALF: aph_lanes = bus_i.haddr[1] ? 4'b1100 : 4'b0011;
			HSIZE_WORD: aph_lanes = 4'b1111;
			default:    aph_lanes = 4'b1111;
		endcase
	end

	always_ff @(posedge clk) begin
		if (aph_accept) begin
			dph_word   <= bus_i.haddr[AW+1:2];
			dph_write  <= bus_i.hwrite;
			dph_excl   <= bus_i.hexcl;
			dph_lanes  <= aph_lanes;
			dph_master <= bus_i.hmaster;
		end
	end

	// ------------------------------------------------------------------
	// Wait and error FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			wait_cnt <= '0;
			dph_vld  <= 1'b0;
		end else begin
			// Errored transfers never get a valid data phase
			if (bus_i.hready)
				dph_vld <= aph_accept && aph_in_range;
			case (state)
				ST_IDLE, ST_ERR_SECOND: begin
					if (aph_accept && !aph_in_range) begin
						state <= ST_ERR_FIRST;
					end else if (aph_accept && (WAIT != 0)) begin
						state    <= ST_WAIT;
						wait_cnt <= CW'(WAIT - 1);
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_WAIT: begin
					if (wait_cnt == '0)
						state <= ST_IDLE;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				ST_ERR_FIRST: state <= ST_ERR_SECOND;
				default:      state <= ST_IDLE;
			endcase
		end
	end

	assign bus_i.hready = (state == ST_IDLE) || (state == ST_ERR_SECOND);
	assign bus_i.hresp  = (state == ST_ERR_FIRST) || (state == ST_ERR_SECOND);

	// Data phase ends this cycle
	assign dph_done = dph_vld && (state == ST_IDLE);

	// ------------------------------------------------------------------
	// Storage and exclusive monitor

	assign excl_ok = resv_vld && (resv_word == dph_word) && (resv_master == dph_master);

	// Exclusive reads always report okay, the reservation is now set
	assign bus_i.hexokay = dph_done && dph_excl && (!dph_write || excl_ok);
	assign bus_i.hrdata  = mem[dph_word];

	// Failed exclusive writes leave memory alone
	always_ff @(posedge clk) begin
		if (dph_done && dph_write && (!dph_excl || excl_ok)) begin
			for (int b = 0; b < 4; b++) begin
				if (dph_lanes[b])
					mem[dph_word][8*b +: 8] <= bus_i.hwdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resv_vld <= 1'b0;
		end else if (dph_done) begin
			if (dph_excl && !dph_write) begin
				resv_vld    <= 1'b1;
				resv_word   <= dph_word;
				resv_master <= dph_master;
			end else if (dph_excl && dph_write) begin
				resv_vld <= 1'b0;
			end else if (dph_write && (dph_word == resv_word)) begin
				// Plain store to the reserved word, from any master
				resv_vld <= 1'b0;
			end
		end
	end

	a_no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE) |-> !bus_i.hresp)
		else $error("hresp high in idle state");

endmodule

`default_nettype wire

// File: design/cpu_bus_1port.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_1port (
	input  wire                    clk,
	input  wire                    rst_n,

	// Instruction fetch requester
	input  wire                    i_aph_req_i,
	input  wire                    i_aph_panic_i,
	input  wire bus_pkg::haddr_t   i_haddr_i,
	input  wire bus_pkg::hsize_t   i_hsize_i,
	input  wire                    i_priv_i,
	output bus_pkg::hdata_t        i_rdata_o,
	output logic                   i_aph_ready_o,
	output logic                   i_dph_ready_o,
	output logic                   i_dph_err_o,

	// Load/store requester
	input  wire                    d_aph_req_i,
	input  wire                    d_aph_excl_i,
	input  wire bus_pkg::haddr_t   d_haddr_i,
	input  wire bus_pkg::hsize_t   d_hsize_i,
	input  wire                    d_priv_i,
	input  wire                    d_hwrite_i,
	input  wire bus_pkg::hdata_t   d_wdata_i,
	output bus_pkg::hdata_t        d_rdata_o,
	output logic                   d_aph_ready_o,
	output logic                   d_dph_ready_o,
	output logic                   d_dph_err_o,
	output logic                   d_dph_exokay_o,

	// Debugger system bus
	input  wire bus_pkg::haddr_t   s_addr_i,
	input  wire                    s_write_i,
	input  wire [1:0]              s_size_i,
	input  wire                    s_vld_i,
	input  wire bus_pkg::hdata_t   s_wdata_i,
	output bus_pkg::hdata_t        s_rdata_o,
	output logic                   s_rdy_o,
	output logic                   s_err_o
);

	// Shared bus between arbiter and SRAM
	ahb_if bus ();

	ahb_port_arbiter u_arb (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_aph_req_i    (i_aph_req_i),
		.i_aph_panic_i  (i_aph_panic_i),
		.i_haddr_i      (i_haddr_i),
		.i_hsize_i      (i_hsize_i),
		.i_priv_i       (i_priv_i),
		.i_aph_ready_o  (i_aph_ready_o),
		.i_dph_ready_o  (i_dph_ready_o),
		.i_dph_err_o    (i_dph_err_o),
		.i_rdata_o      (i_rdata_o),
		.d_aph_req_i    (d_aph_req_i),
		.d_aph_excl_i   (d_aph_excl_i),
		.d_haddr_i      (d_haddr_i),
		.d_hsize_i      (d_hsize_i),
		.d_priv_i       (d_priv_i),
		.d_hwrite_i     (d_hwrite_i),
		.d_wdata_i      (d_wdata_i),
		.d_aph_ready_o  (d_aph_ready_o),
		.d_dph_ready_o  (d_dph_ready_o),
		.d_dph_err_o    (d_dph_err_o),
		.d_dph_exokay_o (d_dph_exokay_o),
		.d_rdata_o      (d_rdata_o),
		.s_addr_i       (s_addr_i),
		.s_write_i      (s_write_i),
		.s_size_i       (s_size_i),
		.s_vld_i        (s_vld_i),
		.s_wdata_i      (s_wdata_i),
		.s_rdy_o        (s_rdy_o),
		.s_err_o        (s_err_o),
		.s_rdata_o      (s_rdata_o),
		.bus_o          (bus.manager)
	);

	// Depth and wait states from the settings defaults
	ahb_sram u_sram (
		.clk   (clk),
		.rst_n (rst_n),
		.bus_i (bus.subordinate)
	);

endmodule

`default_nettype wire

// File: verif/cpu_bus_1port_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module cpu_bus_1port_tb;
	import bus_pkg::*;

	localparam int     WAIT    = `BUS_SRAM_WAIT;
	localparam int     DEPTH   = `BUS_SRAM_DEPTH_WORDS;
	localparam int     AW      = $clog2(DEPTH);
	localparam int     TIMEOUT = 50;
	localparam haddr_t LIMIT   = haddr_t'(4 * DEPTH);

	logic clk;
	logic rst_n;

	// Fetch port
	logic   i_aph_req_i, i_aph_panic_i, i_priv_i;
	haddr_t i_haddr_i;
	hsize_t i_hsize_i;
	logic   i_aph_ready_o, i_dph_ready_o, i_dph_err_o;
	hdata_t i_rdata_o;

	// Load/store port
	logic   d_aph_req_i, d_aph_excl_i, d_priv_i, d_hwrite_i;
	haddr_t d_haddr_i;
	hsize_t d_hsize_i;
	hdata_t d_wdata_i;
	logic   d_aph_ready_o, d_dph_ready_o, d_dph_err_o, d_dph_exokay_o;
	hdata_t d_rdata_o;

	// Debug port
	haddr_t     s_addr_i;
	logic       s_write_i, s_vld_i;
	logic [1:0] s_size_i;
	hdata_t     s_wdata_i;
	logic       s_rdy_o, s_err_o;
	hdata_t     s_rdata_o;

	// Expectations per requester
	logic   i_busy, i_err_exp, i_rd_chk, i_acc_seen;
	hdata_t i_exp;
	logic   d_busy, d_err_exp, d_rd_chk, d_xok_chk, d_xok_exp;
	hdata_t d_exp;
	logic   s_busy, s_err_exp, s_rd_chk;
	hdata_t s_exp;
	logic       prio_chk, hold_chk;
	logic [1:0] prio_exp;

	hdata_t      ref_mem [DEPTH];
	logic [31:0] lfsr;

	cpu_bus_1port u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Helpers

	task automatic check_fail(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "check error");
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	// Galois LFSR, x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// New bytes land only on the lanes picked by size and address
	function automatic hdata_t merge_lanes(input hdata_t old_w, input hdata_t new_w,
		input haddr_t a, input hsize_t sz);
		hdata_t m;
		case (sz)
			HSIZE_BYTE: m = 32'h0000_00ff << (8 * a[1:0]);
			HSIZE_HALF: m = a[1] ? 32'hffff_0000 : 32'h0000_ffff;
			default:    m = 32'hffff_ffff;
		endcase
		return (old_w & ~m) | (new_w & m);
	endfunction

	// ------------------------------------------------------------------
	// Requester tasks

	task automatic i_read(input haddr_t a, input logic panic);
		int n;
		@(negedge clk);
		i_busy = 1'b1;
		i_haddr_i = a;
		i_hsize_i = HSIZE_WORD;
		i_aph_panic_i = panic;
		i_aph_req_i = 1'b1;
		i_err_exp = (a >= LIMIT);
		i_rd_chk = (a < LIMIT);
		i_exp = ref_mem[a[AW+1:2]];
		n = 0;
		#1;
		while (!i_aph_ready_o) begin
			@(negedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				timeout_fail("fetch address phase");
		end
		i_acc_seen = 1'b1;
		@(negedge clk);
		i_aph_req_i = 1'b0;
		i_aph_panic_i = 1'b0;
		n = 0;
		#1;
		while (!i_dph_ready_o) begin
			@(negedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				timeout_fail("fetch data phase");
		end
		@(negedge clk);
		i_busy = 1'b0;
		i_rd_chk = 1'b0;
		i_err_exp = 1'b0;
	endtask

	task automatic d_access(input haddr_t a, input hsize_t sz, input logic wr,
		input logic excl, input hdata_t wd, input logic xok);
		int n;
		@(negedge clk);
		d_busy = 1'b1;
		d_haddr_i = a;
		d_hsize_i = sz;
		d_hwrite_i = wr;
		d_aph_excl_i = excl;
		// Held through the data phase
		d_wdata_i = wd;
		d_aph_req_i = 1'b1;
		d_err_exp = (a >= LIMIT);
		d_rd_chk = !wr && (a < LIMIT);
		d_exp = ref_mem[a[AW+1:2]];
		d_xok_chk = excl && wr;
		d_xok_exp = xok;
		n = 0;
		#1;
		while (!d_aph_ready_o) begin
			@(negedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				timeout_fail("load/store address phase");
		end
		@(negedge clk);
		d_aph_req_i = 1'b0;
		d_aph_excl_i = 1'b0;
		n = 0;
		#1;
		while (!d_dph_ready_o) begin
			@(negedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				timeout_fail("load/store data phase");
		end
		@(negedge clk);
		if (wr && (a < LIMIT) && (!excl || xok))
			ref_mem[a[AW+1:2]] = merge_lanes(ref_mem[a[AW+1:2]], wd, a, sz);
		d_busy = 1'b0;
		d_rd_chk = 1'b0;
		d_xok_chk = 1'b0;
		d_err_exp = 1'b0;
	endtask

	task automatic s_access(input haddr_t a, input logic [1:0] sz, input logic wr,
		input hdata_t wd);
		int n;
		@(negedge clk);
		s_busy = 1'b1;
		s_addr_i = a;
		s_size_i = sz;
		s_write_i = wr;
		s_wdata_i = wd;
		s_vld_i = 1'b1;
		s_err_exp = (a >= LIMIT);
		s_rd_chk = !wr && (a < LIMIT);
		s_exp = ref_mem[a[AW+1:2]];
		n = 0;
		#1;
		while (!s_rdy_o) begin
			@(negedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				timeout_fail("debug response");
		end
		@(negedge clk);
		s_vld_i = 1'b0;
		if (wr && (a < LIMIT))
			ref_mem[a[AW+1:2]] = merge_lanes(ref_mem[a[AW+1:2]], wd, a, {1'b0, sz});
		s_busy = 1'b0;
		s_rd_chk = 1'b0;
		s_err_exp = 1'b0;
	endtask

	// Same-cycle requests on a free bus, exp is {fetch, load/store} aph_ready
	task automatic prio_case(input logic use_i, input logic panic, input logic use_d,
		input logic use_s, input logic [1:0] exp, input haddr_t a);
		@(negedge clk);
		prio_exp = exp;
		fork
			begin
				if (use_i)
					i_read(a, panic);
			end
			begin
				if (use_d)
					d_access(a, HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);
			end
			begin
				if (use_s)
					s_access(a, 2'd2, 1'b0, '0);
			end
			begin
				@(negedge clk);
				prio_chk = 1'b1;
				@(negedge clk);
				prio_chk = 1'b0;
			end
		join
	endtask

	// ------------------------------------------------------------------
	// Checks

	a_rd_i: assert property (@(posedge clk) disable iff (!rst_n)
		i_dph_ready_o && i_rd_chk |-> i_rdata_o == i_exp)
		else check_fail("fetch read data mismatch");
	a_rd_d: assert property (@(posedge clk) disable iff (!rst_n)
		d_dph_ready_o && d_rd_chk |-> d_rdata_o == d_exp)
		else check_fail("load/store read data mismatch");
	a_rd_s: assert property (@(posedge clk) disable iff (!rst_n)
		s_rdy_o && s_rd_chk |-> s_rdata_o == s_exp)
		else check_fail("debug read data mismatch");

	// Response goes to the owner only
	a_owner: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({i_dph_ready_o, d_dph_ready_o, s_rdy_o}))
		else check_fail("ready on more than one requester");
	a_own_i: assert property (@(posedge clk) disable iff (!rst_n) i_dph_ready_o |-> i_busy)
		else check_fail("fetch ready without a transfer");
	a_own_d: assert property (@(posedge clk) disable iff (!rst_n) d_dph_ready_o |-> d_busy)
		else check_fail("load/store ready without a transfer");
	a_own_s: assert property (@(posedge clk) disable iff (!rst_n) s_rdy_o |-> s_busy)
		else check_fail("debug ready without a transfer");

	// WAIT+1 cycles from accept to ready
	a_lat_i: assert property (@(posedge clk) disable iff (!rst_n)
		i_aph_req_i && i_aph_ready_o && (i_haddr_i < LIMIT)
		|=> !i_dph_ready_o ##(WAIT) i_dph_ready_o)
		else check_fail("fetch response timing");
	a_lat_d: assert property (@(posedge clk) disable iff (!rst_n)
		d_aph_req_i && d_aph_ready_o && (d_haddr_i < LIMIT)
		|=> !d_dph_ready_o ##(WAIT) d_dph_ready_o)
		else check_fail("load/store response timing");

	// Two-cycle error, ready on the second
	a_err_i: assert property (@(posedge clk) disable iff (!rst_n) i_dph_err_o |-> i_err_exp)
		else check_fail("unexpected fetch error");
	a_err_d: assert property (@(posedge clk) disable iff (!rst_n) d_dph_err_o |-> d_err_exp)
		else check_fail("unexpected load/store error");
	a_err_s: assert property (@(posedge clk) disable iff (!rst_n) s_err_o |-> s_err_exp)
		else check_fail("unexpected debug error");
	a_err2_d: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(d_dph_err_o) |-> !d_dph_ready_o ##1 (d_dph_err_o && d_dph_ready_o))
		else check_fail("load/store error shape");
	a_err2_i: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_dph_err_o) |-> !i_dph_ready_o ##1 (i_dph_err_o && i_dph_ready_o))
		else check_fail("fetch error shape");
	a_err2_s: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(s_err_o) |-> !s_rdy_o ##1 (s_err_o && s_rdy_o))
		else check_fail("debug error shape");

	a_xok: assert property (@(posedge clk) disable iff (!rst_n)
		d_dph_ready_o && d_xok_chk |-> d_dph_exokay_o == d_xok_exp)
		else check_fail("exclusive write exokay wrong");
	a_prio: assert property (@(posedge clk) disable iff (!rst_n)
		prio_chk |-> {i_aph_ready_o, d_aph_ready_o} == prio_exp)
		else check_fail("wrong priority winner");
	// Stalled fetch keeps its grant over a later load/store
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hold_chk && d_aph_ready_o |-> i_acc_seen)
		else check_fail("load/store overtook a stalled fetch");

	// ------------------------------------------------------------------
	// Stimulus

	initial begin
		haddr_t      addrs [6];
		logic [31:0] r;
		logic [31:0] off;
		haddr_t      xa;

		{i_aph_req_i, i_aph_panic_i, i_priv_i, i_haddr_i} = '0;
		i_hsize_i = HSIZE_WORD;
		{d_aph_req_i, d_aph_excl_i, d_priv_i, d_hwrite_i, d_haddr_i, d_wdata_i} = '0;
		d_hsize_i = HSIZE_WORD;
		{s_addr_i, s_write_i, s_vld_i, s_size_i, s_wdata_i} = '0;
		{i_busy, i_err_exp, i_rd_chk, i_acc_seen, i_exp} = '0;
		{d_busy, d_err_exp, d_rd_chk, d_xok_chk, d_xok_exp, d_exp} = '0;
		{s_busy, s_err_exp, s_rd_chk, s_exp} = '0;
		{prio_chk, hold_chk, prio_exp} = '0;
		lfsr = 32'he75a_285b;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Full words first, alternating load/store and debug
		for (int k = 0; k < 6; k++) begin
			take_bits(AW, r);
			addrs[k] = haddr_t'({r[AW-1:0], 2'b00});
			take_bits(32, r);
			if (k % 2 == 0)
				d_access(addrs[k], HSIZE_WORD, 1'b1, 1'b0, r, 1'b0);
			else
				s_access(addrs[k], 2'd2, 1'b1, r);
		end
		// Byte and halfword merges
		for (int k = 0; k < 6; k++) begin
			take_bits(2, off);
			take_bits(32, r);
			d_access(addrs[k] + off, HSIZE_BYTE, 1'b1, 1'b0, r, 1'b0);
			take_bits(32, r);
			s_access(addrs[k] + {off[0], 1'b0}, 2'd1, 1'b1, r);
			take_bits(32, r);
			s_access(addrs[k] + off[1:0], 2'd0, 1'b1, r);
			take_bits(32, r);
			d_access(addrs[k] + {~off[1], 1'b0}, HSIZE_HALF, 1'b1, 1'b0, r, 1'b0);
		end
		for (int k = 0; k < 6; k++) begin
			i_read(addrs[k], 1'b0);
			d_access(addrs[k], HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);
			s_access(addrs[k], 2'd2, 1'b0, '0);
		end

		// Priority order
		prio_case(1'b1, 1'b1, 1'b1, 1'b1, 2'b10, addrs[0]);
		prio_case(1'b1, 1'b0, 1'b1, 1'b1, 2'b01, addrs[1]);
		prio_case(1'b1, 1'b0, 1'b0, 1'b1, 2'b00, addrs[2]);
		prio_case(1'b1, 1'b0, 1'b0, 1'b0, 2'b10, addrs[3]);

		// Fetch stalls behind a debug data phase, load/store comes later
		i_acc_seen = 1'b0;
		fork
			s_access(addrs[3], 2'd2, 1'b0, '0);
			begin
				@(negedge clk);
				i_read(addrs[4], 1'b0);
			end
			begin
				repeat (2) @(negedge clk);
				hold_chk = 1'b1;
				d_access(addrs[5], HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);
			end
		join
		hold_chk = 1'b0;

		// Out of range, aliasing the low bits of a live word
		take_bits(32, r);
		d_access(LIMIT | addrs[0], HSIZE_WORD, 1'b1, 1'b0, r, 1'b0);
		d_access(LIMIT | addrs[0], HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);
		i_read(LIMIT | addrs[1], 1'b0);
		s_access(LIMIT | addrs[0], 2'd2, 1'b1, r);
		d_access(addrs[0], HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);

		// Exclusive pair succeeds
		xa = addrs[1];
		take_bits(32, r);
		d_access(xa, HSIZE_WORD, 1'b0, 1'b1, '0, 1'b0);
		d_access(xa, HSIZE_WORD, 1'b1, 1'b1, r, 1'b1);
		d_access(xa, HSIZE_WORD, 1'b0, 1'b0, '0, 1'b0);

		// Debug write breaks the reservation
		d_access(xa, HSIZE_WORD, 1'b0, 1'b1, '0, 1'b0);
		take_bits(32, r);
		s_access(xa, 2'd2, 1'b1, r);
		take_bits(32, r);
		d_access(xa, HSIZE_WORD, 1'b1, 1'b1, r, 1'b0);
		s_access(xa, 2'd2, 1'b0, '0);
		i_read(xa, 1'b0);

		repeat (4) @(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_bus_1port.f
+incdir+design
design/bus_pkg.sv
design/ahb_if.sv
design/ahb_port_arbiter.sv
design/ahb_sram.sv
design/cpu_bus_1port.sv
verif/cpu_bus_1port_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run with Verilator; exit status is the test result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_bus_1port_tb \
	-f cpu_bus_1port.f \
	-o sim_cpu_bus_1port \
	&& ./obj_dir/sim_cpu_bus_1port \
	|| { echo "simulation run failed"; exit 1; }

exit 0
